// ==== mem_fabric_settings.svh ====
// constants shared by the memory fabric, all in the clk_8mhz domain
// region codes are address bits 31:28 of the cpu or loader bus
// the pad register block is 16 words wide, only 12 are populated

`ifndef MEM_FABRIC_SETTINGS_SVH
`define MEM_FABRIC_SETTINGS_SVH

//////////////////////////////////////////////////
// address map

`define MF_REGION_RAM    4'h0
`define MF_REGION_PAD    4'h2
`define MF_REGION_BRIDGE 4'h4
`define MF_REGION_LOAD   4'h5

// first controller register
`define MF_PAD_BASE      32'h2000_0000

//////////////////////////////////////////////////
// sizes

// 2^15 words of 32 bits, 128 KB
`define MF_RAM_AW        15
`define MF_SYNC_STAGES   3
`define MF_NUM_PADS      4

`endif

// ==== mem_fabric_pkg.sv ====
// bus and controller types for the memory fabric
// region decode lives here so the cpu side and the loader agree on it

`default_nettype none

`include "mem_fabric_settings.svh"

package mem_fabric_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;

  // word index into the cpu ram
  typedef logic [`MF_RAM_AW-1:0] ram_addr_t;

  typedef enum logic [2:0] {
    REGION_RAM,
    REGION_PAD,
    REGION_BRIDGE,
    REGION_LOAD,
    REGION_NONE
  } region_e;

  // controller words, see the key bitmap of the host
  typedef logic [15:0] key_t;
  // lstick x/y in the low half, rstick x/y in the high half
  typedef logic [31:0] joy_t;
  // ltrig in bits 7:0, rtrig in bits 15:8
  typedef logic [15:0] trig_t;

  function automatic region_e decode_region(input word_t addr);
    case (addr[31:28])
      `MF_REGION_RAM:    return REGION_RAM;
      `MF_REGION_PAD:    return REGION_PAD;
      `MF_REGION_BRIDGE: return REGION_BRIDGE;
      `MF_REGION_LOAD:   return REGION_LOAD;
      default:           return REGION_NONE;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== ram_port_if.sv ====
// shared port of the cpu ram, clk_8mhz domain
// busy is high whenever ld_we is; the cpu access is not taken that cycle
// rdata is valid one cycle after an accepted cpu_ce

`default_nettype none

interface ram_port_if;

  // cpu side request
  logic                      cpu_ce;
  mem_fabric_pkg::ram_addr_t cpu_addr;
  mem_fabric_pkg::word_t     cpu_wdata;
  mem_fabric_pkg::strb_t     cpu_wstrb;

  // loader side, full word writes only
  logic                      ld_we;
  mem_fabric_pkg::ram_addr_t ld_addr;
  mem_fabric_pkg::word_t     ld_wdata;

  // ram response
  mem_fabric_pkg::word_t     rdata;
  logic                      busy;

  modport decoder (output cpu_ce, cpu_addr, cpu_wdata, cpu_wstrb, input rdata, busy);
  modport loader (output ld_we, ld_addr, ld_wdata);
  modport ram (
    input  cpu_ce, cpu_addr, cpu_wdata, cpu_wstrb, ld_we, ld_addr, ld_wdata,
    output rdata, busy
  );

endinterface

`default_nettype wire

// ==== input_sync.sv ====
// plain register chain for slow inputs from another domain
// o_q is unknown until the chain has clocked MF_SYNC_STAGES times
// a multi-bit payload may be seen torn for one cycle

`default_nettype none

`include "mem_fabric_settings.svh"

module input_sync #(
  parameter type payload_t = logic
) (
  input  wire      clk_8mhz,
  input  payload_t i_d,
  output payload_t o_q
);

  payload_t stage [`MF_SYNC_STAGES];

  always_ff @(posedge clk_8mhz) begin
    stage[0] <= i_d;
    for (int i = 1; i < `MF_SYNC_STAGES; i++) begin
      stage[i] <= stage[i-1];
    end
  end

  assign o_q = stage[`MF_SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== pad_regs.sv ====
// controller registers, 12 populated words of a 16 word block
// index 0-3 key, 4-7 joy, 8-11 trig, 12-15 read zero
// o_pad_rdata is registered, valid one cycle after the index settles

`default_nettype none

`include "mem_fabric_settings.svh"

module pad_regs (
  input  wire                     clk_8mhz,
  input  wire                     rst,
  input  mem_fabric_pkg::key_t    i_cont_key  [`MF_NUM_PADS],
  input  mem_fabric_pkg::joy_t    i_cont_joy  [`MF_NUM_PADS],
  input  mem_fabric_pkg::trig_t   i_cont_trig [`MF_NUM_PADS],
  input  wire [3:0]               i_pad_index,
  output mem_fabric_pkg::word_t   o_pad_rdata
);

  mem_fabric_pkg::key_t  key_s  [`MF_NUM_PADS];
  mem_fabric_pkg::joy_t  joy_s  [`MF_NUM_PADS];
  mem_fabric_pkg::trig_t trig_s [`MF_NUM_PADS];
  mem_fabric_pkg::word_t sel;

  //////////////////////////////////////////////////
  // one synchronizer per controller word

  for (genvar p = 0; p < `MF_NUM_PADS; p++) begin : g_pad
    input_sync #(.payload_t(mem_fabric_pkg::key_t)) u_key_sync (
      .clk_8mhz(clk_8mhz),
      .i_d     (i_cont_key[p]),
      .o_q     (key_s[p])
    );

    input_sync #(.payload_t(mem_fabric_pkg::joy_t)) u_joy_sync (
      .clk_8mhz(clk_8mhz),
      .i_d     (i_cont_joy[p]),
      .o_q     (joy_s[p])
    );

    input_sync #(.payload_t(mem_fabric_pkg::trig_t)) u_trig_sync (
      .clk_8mhz(clk_8mhz),
      .i_d     (i_cont_trig[p]),
      .o_q     (trig_s[p])
    );
  end

  //////////////////////////////////////////////////
  // upper index bits pick the bank

  always_comb begin
    case (i_pad_index[3:2])
      2'd0:    sel = mem_fabric_pkg::word_t'(key_s[i_pad_index[1:0]]);
      2'd1:    sel = joy_s[i_pad_index[1:0]];
      2'd2:    sel = mem_fabric_pkg::word_t'(trig_s[i_pad_index[1:0]]);
      default: sel = '0;
    endcase
  end

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      o_pad_rdata <= '0;
    end else begin
      o_pad_rdata <= sel;
    end
  end

endmodule

`default_nettype wire

// ==== host_loader.sv ====
// host loader write path into the cpu ram
// i_load_wr is a single cycle strobe already in clk_8mhz
// strobes must be at least two cycles apart

`default_nettype none

`include "mem_fabric_settings.svh"

module host_loader (
  input  wire                   clk_8mhz,
  input  wire                   rst,
  input  wire                   i_load_wr,
  input  mem_fabric_pkg::word_t i_load_addr,
  input  mem_fabric_pkg::word_t i_load_data,
  ram_port_if.loader            ram
);

  // only region 0x5 strobes turn into ram writes
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      ram.ld_we <= 1'b0;
    end else begin
      ram.ld_we <= i_load_wr &&
        (mem_fabric_pkg::decode_region(i_load_addr) == mem_fabric_pkg::REGION_LOAD);
    end
  end

  // host words arrive big-endian, swap into cpu byte order
  always_ff @(posedge clk_8mhz) begin
    if (i_load_wr) begin
      ram.ld_addr  <= i_load_addr[`MF_RAM_AW+1:2];
      ram.ld_wdata <= {i_load_data[7:0], i_load_data[15:8],
                       i_load_data[23:16], i_load_data[31:24]};
    end
  end

  // back to back strobes would overwrite the captured word
  a_strobe_spacing: assert property (
    @(posedge clk_8mhz) disable iff (rst) i_load_wr |=> !i_load_wr
  );

endmodule

`default_nettype wire

// ==== cpu_ram.sv ====
// 128 KB cpu ram built from four byte lanes
// loader writes win the cycle and set all lanes
// read data is registered and only updates on an access

`default_nettype none

`include "mem_fabric_settings.svh"

module cpu_ram (
  input wire      clk_8mhz,
  ram_port_if.ram ram
);

  logic                      ce;
  mem_fabric_pkg::ram_addr_t addr;
  mem_fabric_pkg::word_t     wdata;
  mem_fabric_pkg::strb_t     we;

  //////////////////////////////////////////////////
  // port arbitration

  // the cpu side sees busy and retries next cycle
  assign ram.busy = ram.ld_we;

  assign ce    = ram.ld_we || ram.cpu_ce;
  assign addr  = ram.ld_we ? ram.ld_addr : ram.cpu_addr;
  assign wdata = ram.ld_we ? ram.ld_wdata : ram.cpu_wdata;

  always_comb begin
    if (ram.ld_we) begin
      we = 4'hf;
    end else if (ram.cpu_ce) begin
      we = ram.cpu_wstrb;
    end else begin
      we = 4'h0;
    end
  end

  //////////////////////////////////////////////////
  // lane memories

  for (genvar lane = 0; lane < 4; lane++) begin : g_lane
    logic [7:0] mem [2**`MF_RAM_AW];
    logic [7:0] rd_q;

    // read-before-write within a lane
    always_ff @(posedge clk_8mhz) begin
      if (ce) begin
        if (we[lane]) begin
          mem[addr] <= wdata[lane*8 +: 8];
        end
        rd_q <= mem[addr];
      end
    end
  end

  assign ram.rdata = {g_lane[3].rd_q, g_lane[2].rd_q, g_lane[1].rd_q, g_lane[0].rd_q};

endmodule

`default_nettype wire

// ==== region_decoder.sv ====
// cpu bus decode over address bits 31:28
// ram, pad and unmapped accesses complete one cycle after valid,
// stretched by ram busy; bridge accesses end the cycle after the ack
// the cpu must hold valid, addr, wdata and wstrb until ready

`default_nettype none

`include "mem_fabric_settings.svh"

module region_decoder (
  input  wire                   clk_8mhz,
  input  wire                   rst,
  input  wire                   i_cpu_valid,
  input  mem_fabric_pkg::word_t i_cpu_addr,
  input  mem_fabric_pkg::word_t i_cpu_wdata,
  input  mem_fabric_pkg::strb_t i_cpu_wstrb,
  output mem_fabric_pkg::word_t o_cpu_rdata,
  output logic                  o_cpu_ready,
  input  mem_fabric_pkg::word_t i_pad_rdata,
  output logic [3:0]            o_pad_index,
  output logic                  o_bridge_req,
  output mem_fabric_pkg::word_t o_bridge_addr,
  output mem_fabric_pkg::word_t o_bridge_wdata,
  output mem_fabric_pkg::strb_t o_bridge_wstrb,
  input  wire                   i_bridge_ack_pulse,
  input  mem_fabric_pkg::word_t i_bridge_rdata,
  ram_port_if.decoder           ram
);

  mem_fabric_pkg::region_e region;
  mem_fabric_pkg::word_t   bridge_rdata_q;
  logic                    pad_hit;
  logic                    pending;
  logic                    local_done;
  logic                    bridge_done;

  assign region  = mem_fabric_pkg::decode_region(i_cpu_addr);
  assign pad_hit = ({i_cpu_addr[31:6], 6'b0} == `MF_PAD_BASE);

  // valid access that has not reached its ready cycle
  assign pending = i_cpu_valid && !o_cpu_ready;

  //////////////////////////////////////////////////
  // downstream requests

  assign ram.cpu_ce    = pending && (region == mem_fabric_pkg::REGION_RAM);
  assign ram.cpu_addr  = i_cpu_addr[`MF_RAM_AW+1:2];
  assign ram.cpu_wdata = i_cpu_wdata;
  assign ram.cpu_wstrb = i_cpu_wstrb;

  assign o_pad_index = i_cpu_addr[5:2];

  assign o_bridge_req   = pending && (region == mem_fabric_pkg::REGION_BRIDGE);
  assign o_bridge_addr  = i_cpu_addr;
  assign o_bridge_wdata = i_cpu_wdata;
  assign o_bridge_wstrb = i_cpu_wstrb;

  //////////////////////////////////////////////////
  // ready generation

  // unmapped and loader-only regions finish like ram
  assign local_done  = pending && !ram.busy && (region != mem_fabric_pkg::REGION_BRIDGE);
  assign bridge_done = o_bridge_req && i_bridge_ack_pulse;

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      o_cpu_ready <= 1'b0;
    end else begin
      o_cpu_ready <= local_done || bridge_done;
    end
  end

  always_ff @(posedge clk_8mhz) begin
    if (i_bridge_ack_pulse) begin
      bridge_rdata_q <= i_bridge_rdata;
    end
  end

  //////////////////////////////////////////////////
  // read data mux

  // the address is still held in the ready cycle
  always_comb begin
    case (region)
      mem_fabric_pkg::REGION_RAM:    o_cpu_rdata = ram.rdata;
      mem_fabric_pkg::REGION_PAD:    o_cpu_rdata = pad_hit ? i_pad_rdata : '0;
      mem_fabric_pkg::REGION_BRIDGE: o_cpu_rdata = bridge_rdata_q;
      default:                       o_cpu_rdata = '0;
    endcase
  end

  a_ready_pulse: assert property (
    @(posedge clk_8mhz) disable iff (rst) o_cpu_ready |=> !o_cpu_ready
  );

  // the host sees one request per access
  a_bridge_req_drop: assert property (
    @(posedge clk_8mhz) disable iff (rst)
      (o_bridge_req && i_bridge_ack_pulse) |=> !o_bridge_req
  );

endmodule

`default_nettype wire

// ==== mem_fabric_top.sv ====
// cpu memory fabric, everything on clk_8mhz with synchronous rst
// cpu bus follows valid/ready, ready is a single cycle pulse
// loader strobes are already in this domain and at least two cycles apart

`default_nettype none

`include "mem_fabric_settings.svh"

module mem_fabric_top (
  input  wire                   clk_8mhz,
  input  wire                   rst,

  // cpu bus
  input  wire                   i_cpu_valid,
  input  mem_fabric_pkg::word_t i_cpu_addr,
  input  mem_fabric_pkg::word_t i_cpu_wdata,
  input  mem_fabric_pkg::strb_t i_cpu_wstrb,
  output mem_fabric_pkg::word_t o_cpu_rdata,
  output logic                  o_cpu_ready,

  // controllers
  input  mem_fabric_pkg::key_t  i_cont_key  [`MF_NUM_PADS],
  input  mem_fabric_pkg::joy_t  i_cont_joy  [`MF_NUM_PADS],
  input  mem_fabric_pkg::trig_t i_cont_trig [`MF_NUM_PADS],

  // host bridge window
  output logic                  o_bridge_req,
  output mem_fabric_pkg::word_t o_bridge_addr,
  output mem_fabric_pkg::word_t o_bridge_wdata,
  output mem_fabric_pkg::strb_t o_bridge_wstrb,
  input  wire                   i_bridge_ack_pulse,
  input  mem_fabric_pkg::word_t i_bridge_rdata,

  // host loader
  input  wire                   i_load_wr,
  input  mem_fabric_pkg::word_t i_load_addr,
  input  mem_fabric_pkg::word_t i_load_data
);

  mem_fabric_pkg::word_t pad_rdata;
  logic [3:0]            pad_index;

  ram_port_if ram_bus ();

  region_decoder u_decoder (
    .clk_8mhz          (clk_8mhz),
    .rst               (rst),
    .i_cpu_valid       (i_cpu_valid),
    .i_cpu_addr        (i_cpu_addr),
    .i_cpu_wdata       (i_cpu_wdata),
    .i_cpu_wstrb       (i_cpu_wstrb),
    .o_cpu_rdata       (o_cpu_rdata),
    .o_cpu_ready       (o_cpu_ready),
    .i_pad_rdata       (pad_rdata),
    .o_pad_index       (pad_index),
    .o_bridge_req      (o_bridge_req),
    .o_bridge_addr     (o_bridge_addr),
    .o_bridge_wdata    (o_bridge_wdata),
    .o_bridge_wstrb    (o_bridge_wstrb),
    .i_bridge_ack_pulse(i_bridge_ack_pulse),
    .i_bridge_rdata    (i_bridge_rdata),
    .ram               (ram_bus.decoder)
  );

  pad_regs u_pad_regs (
    .clk_8mhz   (clk_8mhz),
    .rst        (rst),
    .i_cont_key (i_cont_key),
    .i_cont_joy (i_cont_joy),
    .i_cont_trig(i_cont_trig),
    .i_pad_index(pad_index),
    .o_pad_rdata(pad_rdata)
  );

  host_loader u_loader (
    .clk_8mhz   (clk_8mhz),
    .rst        (rst),
    .i_load_wr  (i_load_wr),
    .i_load_addr(i_load_addr),
    .i_load_data(i_load_data),
    .ram        (ram_bus.loader)
  );

  cpu_ram u_cpu_ram (
    .clk_8mhz(clk_8mhz),
    .ram     (ram_bus.ram)
  );

endmodule

`default_nettype wire

// ==== tb_mem_fabric.sv ====
// random testbench for mem_fabric_top with one clk_8mhz clock of period 40
// the ram model only holds written words and reads stay inside that set
// inputs change and outputs are sampled on the falling edge

`default_nettype none

`include "mem_fabric_settings.svh"

module tb_mem_fabric;

  localparam int N_LOAD     = 24;
  localparam int N_RAM_OPS  = 96;
  localparam int N_COLL     = 4;
  localparam int N_PAD      = 18;
  localparam int N_BRIDGE   = 16;
  localparam int N_UNMAPPED = 8;
  localparam int TOTAL_TXN  = 3 * N_LOAD + N_RAM_OPS + 2 * N_COLL + N_PAD + N_BRIDGE + N_UNMAPPED;

  logic                  clk_8mhz = 1'b0;
  logic                  rst;
  logic                  cpu_valid;
  mem_fabric_pkg::word_t cpu_addr;
  mem_fabric_pkg::word_t cpu_wdata;
  mem_fabric_pkg::strb_t cpu_wstrb;
  mem_fabric_pkg::word_t cpu_rdata;
  logic                  cpu_ready;
  mem_fabric_pkg::key_t  cont_key  [`MF_NUM_PADS];
  mem_fabric_pkg::joy_t  cont_joy  [`MF_NUM_PADS];
  mem_fabric_pkg::trig_t cont_trig [`MF_NUM_PADS];
  logic                  bridge_req;
  mem_fabric_pkg::word_t bridge_addr;
  mem_fabric_pkg::word_t bridge_wdata;
  mem_fabric_pkg::strb_t bridge_wstrb;
  logic                  bridge_ack;
  mem_fabric_pkg::word_t bridge_rdata;
  logic                  load_wr;
  mem_fabric_pkg::word_t load_addr;
  mem_fabric_pkg::word_t load_data;

  // reference model
  logic [31:0] ram_model [int];
  int          idx_list [$];
  logic [15:0] key_model  [`MF_NUM_PADS];
  logic [31:0] joy_model  [`MF_NUM_PADS];
  logic [15:0] trig_model [`MF_NUM_PADS];

  integer seed = 54965;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;
  int     failed_tests = 0;
  int     test_errors;
  string  test_name;

  always #20 clk_8mhz = ~clk_8mhz;

  mem_fabric_top uut (
    .clk_8mhz          (clk_8mhz),
    .rst               (rst),
    .i_cpu_valid       (cpu_valid),
    .i_cpu_addr        (cpu_addr),
    .i_cpu_wdata       (cpu_wdata),
    .i_cpu_wstrb       (cpu_wstrb),
    .o_cpu_rdata       (cpu_rdata),
    .o_cpu_ready       (cpu_ready),
    .i_cont_key        (cont_key),
    .i_cont_joy        (cont_joy),
    .i_cont_trig       (cont_trig),
    .o_bridge_req      (bridge_req),
    .o_bridge_addr     (bridge_addr),
    .o_bridge_wdata    (bridge_wdata),
    .o_bridge_wstrb    (bridge_wstrb),
    .i_bridge_ack_pulse(bridge_ack),
    .i_bridge_rdata    (bridge_rdata),
    .i_load_wr         (load_wr),
    .i_load_addr       (load_addr),
    .i_load_data       (load_data)
  );

  //////////////////////////////////////////////////
  // checking and reporting

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
    tests++;
  endtask

  task automatic end_test();
    if (errors == test_errors) begin
      $display("test %s ok", test_name);
    end else begin
      failed_tests++;
      $display("test %s failed with %0d errors", test_name, errors - test_errors);
    end
  endtask

  // the cpu sees big-endian host words byte-reversed
  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic logic [31:0] pad_expect(input int n);
    if (n < 4) begin
      return {16'h0, key_model[n]};
    end else if (n < 8) begin
      return joy_model[n-4];
    end else if (n < 12) begin
      return {16'h0, trig_model[n-8]};
    end
    return 32'h0;
  endfunction

  //////////////////////////////////////////////////
  // bus drivers that start and return on a falling edge

  task automatic cpu_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output int latency);
    int cycles;
    cpu_valid = 1'b1;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    cpu_wstrb = wstrb;
    @(negedge clk_8mhz);
    cycles = 1;
    while (!cpu_ready && cycles < 40) begin
      @(negedge clk_8mhz);
      cycles++;
    end
    if (!cpu_ready) begin
      errors++;
      $display("no ready pulse within 40 cycles for the access to %h in test %s",
               addr, test_name);
    end
    rdata     = cpu_rdata;
    latency   = cycles;
    cpu_valid = 1'b0;
    cpu_wstrb = 4'h0;
    // idle cycle after ready
    @(negedge clk_8mhz);
  endtask

  task automatic load_word(input int idx, input logic [31:0] data);
    load_wr   = 1'b1;
    load_addr = {4'h5, 11'h0, idx[14:0], 2'b00};
    load_data = data;
    ram_model[idx] = swap_bytes(data);
    @(negedge clk_8mhz);
    load_wr = 1'b0;
    @(negedge clk_8mhz);
  endtask

  task automatic bridge_access(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] wstrb);
    int          delay;
    logic [31:0] resp;
    delay = 1 + ($random(seed) & 7);
    resp  = $random(seed);
    cpu_valid = 1'b1;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    cpu_wstrb = wstrb;
    @(negedge clk_8mhz);
    check_value("bridge req raised", 32'h1, {31'h0, bridge_req});
    check_value("bridge addr", addr, bridge_addr);
    check_value("bridge wdata", wdata, bridge_wdata);
    check_value("bridge wstrb", {28'h0, wstrb}, {28'h0, bridge_wstrb});
    repeat (delay - 1) @(negedge clk_8mhz);
    check_value("bridge ready before ack", 32'h0, {31'h0, cpu_ready});
    bridge_ack   = 1'b1;
    bridge_rdata = resp;
    @(negedge clk_8mhz);
    bridge_ack   = 1'b0;
    bridge_rdata = ~resp;
    check_value("bridge ready after ack", 32'h1, {31'h0, cpu_ready});
    check_value("bridge rdata", resp, cpu_rdata);
    check_value("bridge req dropped", 32'h0, {31'h0, bridge_req});
    cpu_valid = 1'b0;
    cpu_wstrb = 4'h0;
    @(negedge clk_8mhz);
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial begin
    int          idx;
    int          lat;
    logic [31:0] data;
    logic [31:0] rd;
    logic [3:0]  strb;
    logic [3:0]  region;

    rst          = 1'b1;
    // an unmapped access held through reset must not complete
    cpu_valid    = 1'b1;
    cpu_addr     = 32'hf000_0000;
    cpu_wdata    = '0;
    cpu_wstrb    = '0;
    bridge_ack   = 1'b0;
    bridge_rdata = '0;
    load_wr      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    for (int p = 0; p < `MF_NUM_PADS; p++) begin
      cont_key[p]  = '0;
      cont_joy[p]  = '0;
      cont_trig[p] = '0;
    end
    repeat (4) @(negedge clk_8mhz);
    rst       = 1'b0;
    cpu_valid = 1'b0;
    cpu_addr  = '0;

    start_test("reset");
    check_value("ready at reset release", 32'h0, {31'h0, cpu_ready});
    @(negedge clk_8mhz);
    check_value("ready after reset", 32'h0, {31'h0, cpu_ready});
    check_value("bridge req after reset", 32'h0, {31'h0, bridge_req});
    end_test();

    start_test("loader");
    for (int i = 0; i < N_LOAD; i++) begin
      idx = $random(seed) & 32'h7fff;
      idx_list.push_back(idx);
      load_word(idx, $random(seed));
    end
    foreach (idx_list[i]) begin
      cpu_access({15'h0, idx_list[i][14:0], 2'b00}, 32'h0, 4'h0, rd, lat);
      check_value($sformatf("loader readback %0h", idx_list[i]), ram_model[idx_list[i]], rd);
    end
    end_test();

    // strobe 0 reads and any other strobe writes those lanes
    start_test("cpu ram");
    for (int i = 0; i < N_RAM_OPS; i++) begin
      idx  = idx_list[($random(seed) & 32'h7fffffff) % idx_list.size()];
      strb = $random(seed);
      data = $random(seed);
      cpu_access({15'h0, idx[14:0], 2'b00}, data, strb, rd, lat);
      check_value("ram latency", 32'd1, lat);
      if (strb == 4'h0) begin
        check_value($sformatf("ram read %0h", idx), ram_model[idx], rd);
      end else begin
        for (int l = 0; l < 4; l++) begin
          if (strb[l]) begin
            ram_model[idx][l*8 +: 8] = data[l*8 +: 8];
          end
        end
      end
    end
    foreach (idx_list[i]) begin
      cpu_access({15'h0, idx_list[i][14:0], 2'b00}, 32'h0, 4'h0, rd, lat);
      check_value($sformatf("ram final %0h", idx_list[i]), ram_model[idx_list[i]], rd);
    end
    end_test();

    // loader write lands in the first cycle of the cpu read
    start_test("collision");
    for (int i = 0; i < N_COLL; i++) begin
      idx       = $random(seed) & 32'h7fff;
      data      = $random(seed);
      load_wr   = 1'b1;
      load_addr = {4'h5, 11'h0, idx[14:0], 2'b00};
      load_data = data;
      ram_model[idx] = swap_bytes(data);
      @(negedge clk_8mhz);
      load_wr = 1'b0;
      cpu_access({15'h0, idx[14:0], 2'b00}, 32'h0, 4'h0, rd, lat);
      check_value("collision latency", 32'd2, lat);
      check_value($sformatf("collision read %0h", idx), ram_model[idx], rd);
    end
    end_test();

    start_test("pad regs");
    for (int p = 0; p < `MF_NUM_PADS; p++) begin
      key_model[p]  = $random(seed);
      joy_model[p]  = $random(seed);
      trig_model[p] = $random(seed);
      cont_key[p]   = key_model[p];
      cont_joy[p]   = joy_model[p];
      cont_trig[p]  = trig_model[p];
    end
    repeat (3) @(negedge clk_8mhz);
    for (int n = 0; n < 16; n++) begin
      cpu_access(`MF_PAD_BASE + n * 4, 32'h0, 4'h0, rd, lat);
      check_value($sformatf("pad reg %0d", n), pad_expect(n), rd);
    end
    cpu_access(`MF_PAD_BASE + 32'h40, 32'h0, 4'h0, rd, lat);
    check_value("pad past block", 32'h0, rd);
    cpu_access(32'h2abc_0000, 32'h0, 4'h0, rd, lat);
    check_value("pad far offset", 32'h0, rd);
    end_test();

    start_test("bridge");
    for (int i = 0; i < N_BRIDGE; i++) begin
      data = $random(seed);
      bridge_access({4'h4, data[27:0]}, $random(seed), $random(seed));
    end
    end_test();

    start_test("unmapped");
    for (int i = 0; i < N_UNMAPPED; i++) begin
      do begin
        region = $random(seed);
      end while (region == 4'h0 || region == 4'h2 || region == 4'h4);
      data = $random(seed);
      cpu_access({region, data[27:0]}, $random(seed), $random(seed), rd, lat);
      check_value("unmapped latency", 32'd1, lat);
      check_value($sformatf("unmapped read region %0h", region), 32'h0, rd);
    end
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // every transaction fits well inside 20 cycles
  initial begin
    repeat (TOTAL_TXN * 20 + 16) @(posedge clk_8mhz);
    $display("watchdog expired, the run did not reach its end in test %s", test_name);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
mem_fabric_pkg.sv
ram_port_if.sv
input_sync.sv
pad_regs.sv
host_loader.sv
cpu_ram.sv
region_decoder.sv
mem_fabric_top.sv
tb_mem_fabric.sv

// ==== Bender.yml ====
package:
  name: mem_fabric

sources:
  - include_dirs:
      - .
    files:
      - mem_fabric_pkg.sv
      - ram_port_if.sv
      - input_sync.sv
      - pad_regs.sv
      - host_loader.sv
      - cpu_ram.sv
      - region_decoder.sv
      - mem_fabric_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_mem_fabric.sv
